// File: logic/kernel_ctrl_pkg.sv
// Kernel control definitions
package kernel_ctrl_pkg;

  // Word address on the host register bus.
  typedef logic [11:0] reg_addr_t;

  // Register and parameter data word.
  typedef logic [31:0] reg_data_t;

  // Word index into the parameter memory.
  typedef logic [5:0] param_addr_t;

  // Run control states.
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RESET_WAIT,
    CTRL_GO_OFFER,
    CTRL_RUNNING
  } ctrl_state_e;

  // Register map.
  localparam reg_addr_t CTRL_ADDR  = 12'd0;
  localparam reg_addr_t PARAM_BASE = 12'd16;

  // Control register bits.
  localparam int START_BIT = 0;
  // Read only, cleared by a status read.
  localparam int DONE_BIT  = 1;
  localparam int IDLE_BIT  = 2;
  localparam int IE_BIT    = 3;

endpackage

// File: logic/reg_select.sv
// Register bus decode
module reg_select #(
  parameter int PARAM_DEPTH = 64
) (
  input  logic                         ap_clk,
  input  logic                         arst_n,
  input  logic                         reg_req,
  input  logic                         reg_write,
  input  kernel_ctrl_pkg::reg_addr_t   reg_addr,
  input  kernel_ctrl_pkg::reg_data_t   reg_wdata,
  output logic                         reg_ack,
  output kernel_ctrl_pkg::reg_data_t   reg_rdata,
  output logic                         ctrl_wr,
  output logic                         ctrl_rd,
  output kernel_ctrl_pkg::reg_data_t   ctrl_wdata,
  input  kernel_ctrl_pkg::reg_data_t   ctrl_rdata,
  output logic                         host_wr,
  output logic                         host_rd,
  output kernel_ctrl_pkg::param_addr_t host_addr,
  output kernel_ctrl_pkg::reg_data_t   host_wdata,
  input  kernel_ctrl_pkg::reg_data_t   host_rdata
);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_ISSUE,
    PH_WAIT,
    PH_MEM,
    PH_ACK
  } phase_e;

  phase_e                     phase;
  logic                       write_q;
  logic                       ctrl_hit_q;
  logic                       param_hit_q;
  logic                       ctrl_hit;
  logic                       param_hit;
  kernel_ctrl_pkg::reg_data_t wdata_q;

  // Address decode for the request on the bus.
  always_comb begin
    ctrl_hit  = (reg_addr == kernel_ctrl_pkg::CTRL_ADDR);
    param_hit = (reg_addr >= kernel_ctrl_pkg::PARAM_BASE) &&
                (reg_addr < kernel_ctrl_pkg::PARAM_BASE + PARAM_DEPTH);
  end

  assign ctrl_wdata = wdata_q;
  assign host_wdata = wdata_q;

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase       <= PH_IDLE;
      reg_ack     <= 1'b0;
      write_q     <= 1'b0;
      ctrl_hit_q  <= 1'b0;
      param_hit_q <= 1'b0;
      ctrl_wr     <= 1'b0;
      ctrl_rd     <= 1'b0;
      host_wr     <= 1'b0;
      host_rd     <= 1'b0;
    end else begin
      // Strobes last a single cycle.
      ctrl_wr <= 1'b0;
      ctrl_rd <= 1'b0;
      host_wr <= 1'b0;
      host_rd <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (reg_req) begin
            write_q     <= reg_write;
            ctrl_hit_q  <= ctrl_hit;
            param_hit_q <= param_hit;
            phase       <= PH_ISSUE;
          end
        end
        PH_ISSUE: begin
          ctrl_wr <= ctrl_hit_q && write_q;
          ctrl_rd <= ctrl_hit_q && !write_q;
          host_wr <= param_hit_q && write_q;
          host_rd <= param_hit_q && !write_q;
          phase   <= PH_WAIT;
        end
        PH_WAIT: begin
          // Memory reads need one more cycle.
          if (param_hit_q) begin
            phase <= PH_MEM;
          end else begin
            reg_ack <= 1'b1;
            phase   <= PH_ACK;
          end
        end
        PH_MEM: begin
          reg_ack <= 1'b1;
          phase   <= PH_ACK;
        end
        PH_ACK: begin
          if (!reg_req) begin
            reg_ack <= 1'b0;
            phase   <= PH_IDLE;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (phase == PH_IDLE && reg_req) begin
      wdata_q   <= reg_wdata;
      host_addr <= kernel_ctrl_pkg::param_addr_t'(reg_addr - kernel_ctrl_pkg::PARAM_BASE);
    end
    // Unmapped addresses read back as zero.
    if (phase == PH_WAIT && !param_hit_q) begin
      reg_rdata <= ctrl_hit_q ? ctrl_rdata : '0;
    end
    if (phase == PH_MEM) begin
      reg_rdata <= host_rdata;
    end
  end

endmodule

// File: logic/ctrl_regs.sv
// Kernel control register
module ctrl_regs (
  input  logic                       ap_clk,
  input  logic                       arst_n,
  input  logic                       ctrl_wr,
  input  logic                       ctrl_rd,
  input  kernel_ctrl_pkg::reg_data_t ctrl_wdata,
  output kernel_ctrl_pkg::reg_data_t ctrl_rdata,
  output logic                       start_pulse,
  input  logic                       go_holdoff,
  output logic                       go_valid,
  input  logic                       go_stop,
  input  logic                       done_valid,
  output logic                       done_stop,
  output logic                       interrupt
);

  kernel_ctrl_pkg::ctrl_state_e state;
  logic                         done;
  logic                         ie;
  logic                         done_next;
  logic                         ie_next;
  logic                         go_xfer;
  logic                         done_xfer;

  assign go_valid  = (state == kernel_ctrl_pkg::CTRL_GO_OFFER);
  assign done_stop = (state != kernel_ctrl_pkg::CTRL_RUNNING);
  assign go_xfer   = go_valid && !go_stop;
  assign done_xfer = done_valid && !done_stop;

  // Start is only honoured from idle.
  assign start_pulse = ctrl_wr && ctrl_wdata[kernel_ctrl_pkg::START_BIT] &&
                       (state == kernel_ctrl_pkg::CTRL_IDLE);

  // Status word seen by the host.
  always_comb begin
    ctrl_rdata = '0;
    ctrl_rdata[kernel_ctrl_pkg::START_BIT] = (state != kernel_ctrl_pkg::CTRL_IDLE);
    ctrl_rdata[kernel_ctrl_pkg::DONE_BIT]  = done;
    ctrl_rdata[kernel_ctrl_pkg::IDLE_BIT]  = (state == kernel_ctrl_pkg::CTRL_IDLE);
    ctrl_rdata[kernel_ctrl_pkg::IE_BIT]    = ie;
  end

  // A done arriving with a read wins, so it is never lost.
  always_comb begin
    done_next = done;
    if (done_xfer) begin
      done_next = 1'b1;
    end else if (ctrl_rd) begin
      done_next = 1'b0;
    end
    ie_next = ctrl_wr ? ctrl_wdata[kernel_ctrl_pkg::IE_BIT] : ie;
  end

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= kernel_ctrl_pkg::CTRL_IDLE;
      done      <= 1'b0;
      ie        <= 1'b0;
      interrupt <= 1'b0;
    end else begin
      case (state)
        kernel_ctrl_pkg::CTRL_IDLE: begin
          if (start_pulse) state <= kernel_ctrl_pkg::CTRL_RESET_WAIT;
        end
        kernel_ctrl_pkg::CTRL_RESET_WAIT: begin
          // Holdoff is already high on the first edge here.
          if (!go_holdoff) state <= kernel_ctrl_pkg::CTRL_GO_OFFER;
        end
        kernel_ctrl_pkg::CTRL_GO_OFFER: begin
          if (go_xfer) state <= kernel_ctrl_pkg::CTRL_RUNNING;
        end
        kernel_ctrl_pkg::CTRL_RUNNING: begin
          if (done_xfer) state <= kernel_ctrl_pkg::CTRL_IDLE;
        end
        default: state <= kernel_ctrl_pkg::CTRL_IDLE;
      endcase
      done      <= done_next;
      ie        <= ie_next;
      interrupt <= done_next && ie_next;
    end
  end

endmodule

// File: logic/param_mem.sv
// Kernel parameter memory
module param_mem #(
  parameter int PARAM_DEPTH = 64
) (
  input  logic                         ap_clk,
  input  logic                         arst_n,
  input  logic                         host_wr,
  input  logic                         host_rd,
  input  kernel_ctrl_pkg::param_addr_t host_addr,
  input  kernel_ctrl_pkg::reg_data_t   host_wdata,
  output kernel_ctrl_pkg::reg_data_t   host_rdata,
  input  logic                         param_addr_valid,
  input  kernel_ctrl_pkg::param_addr_t param_addr,
  output logic                         param_addr_stop,
  output logic                         param_data_valid,
  output kernel_ctrl_pkg::reg_data_t   param_data,
  input  logic                         param_data_stop
);

  kernel_ctrl_pkg::reg_data_t mem [PARAM_DEPTH];
  kernel_ctrl_pkg::reg_data_t queue [2];
  logic                       wr_ptr;
  logic                       rd_ptr;
  logic [1:0]                 count;
  logic                       push;
  logic                       pop;

  // Two-entry output queue on the fetch side.
  assign param_addr_stop  = (count == 2'd2);
  assign param_data_valid = (count != 2'd0);
  assign param_data       = queue[rd_ptr];
  assign push             = param_addr_valid && !param_addr_stop;
  assign pop              = param_data_valid && !param_data_stop;

  always_ff @(posedge ap_clk) begin
    if (host_wr) begin
      mem[host_addr] <= host_wdata;
    end
    if (host_rd) begin
      host_rdata <= mem[host_addr];
    end
    // Fetched word lands in the queue one cycle after the address.
    if (push) begin
      queue[wr_ptr] <= mem[param_addr];
    end
  end

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: logic/reset_handler.sv
// Kernel reset timer
module reset_handler #(
  parameter int KERNEL_RESET_CYCLES = 4
) (
  input  logic ap_clk,
  input  logic arst_n,
  input  logic start_pulse,
  output logic kernel_reset,
  output logic go_holdoff
);

  localparam int CNT_W = $clog2(KERNEL_RESET_CYCLES + 1);

  logic [CNT_W-1:0] count;

  // Counter sits at full count during reset, so the action
  // stays in reset for a few cycles after release too.
  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= CNT_W'(KERNEL_RESET_CYCLES);
    end else if (start_pulse) begin
      count <= CNT_W'(KERNEL_RESET_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign kernel_reset = (count != '0);

  // Same window, so go is never offered inside the reset.
  assign go_holdoff = (count != '0);

endmodule

// File: logic/kernel_ctrl_top.sv
// Kernel control top level
module kernel_ctrl_top #(
  parameter int PARAM_DEPTH         = 64,
  parameter int KERNEL_RESET_CYCLES = 4
) (
  input  logic                         ap_clk,
  input  logic                         arst_n,
  input  logic                         reg_req,
  input  logic                         reg_write,
  input  kernel_ctrl_pkg::reg_addr_t   reg_addr,
  input  kernel_ctrl_pkg::reg_data_t   reg_wdata,
  output logic                         reg_ack,
  output kernel_ctrl_pkg::reg_data_t   reg_rdata,
  output logic                         go_valid,
  input  logic                         go_stop,
  input  logic                         done_valid,
  output logic                         done_stop,
  output logic                         interrupt,
  output logic                         kernel_reset,
  input  logic                         param_addr_valid,
  input  kernel_ctrl_pkg::param_addr_t param_addr,
  output logic                         param_addr_stop,
  output logic                         param_data_valid,
  output kernel_ctrl_pkg::reg_data_t   param_data,
  input  logic                         param_data_stop
);

  logic                         ctrl_wr;
  logic                         ctrl_rd;
  kernel_ctrl_pkg::reg_data_t   ctrl_wdata;
  kernel_ctrl_pkg::reg_data_t   ctrl_rdata;
  logic                         host_wr;
  logic                         host_rd;
  kernel_ctrl_pkg::param_addr_t host_addr;
  kernel_ctrl_pkg::reg_data_t   host_wdata;
  kernel_ctrl_pkg::reg_data_t   host_rdata;
  logic                         start_pulse;
  logic                         go_holdoff;

  reg_select #(.PARAM_DEPTH(PARAM_DEPTH)) u_reg_select (
    .ap_clk, .arst_n, .reg_req, .reg_write, .reg_addr, .reg_wdata, .reg_ack, .reg_rdata,
    .ctrl_wr, .ctrl_rd, .ctrl_wdata, .ctrl_rdata,
    .host_wr, .host_rd, .host_addr, .host_wdata, .host_rdata
  );

  ctrl_regs u_ctrl_regs (
    .ap_clk, .arst_n, .ctrl_wr, .ctrl_rd, .ctrl_wdata, .ctrl_rdata, .start_pulse,
    .go_holdoff, .go_valid, .go_stop, .done_valid, .done_stop, .interrupt
  );

  param_mem #(.PARAM_DEPTH(PARAM_DEPTH)) u_param_mem (
    .ap_clk, .arst_n, .host_wr, .host_rd, .host_addr, .host_wdata, .host_rdata,
    .param_addr_valid, .param_addr, .param_addr_stop,
    .param_data_valid, .param_data, .param_data_stop
  );

  // Action reset follows each start.
  reset_handler #(.KERNEL_RESET_CYCLES(KERNEL_RESET_CYCLES)) u_reset_handler (
    .ap_clk, .arst_n, .start_pulse, .kernel_reset, .go_holdoff
  );

endmodule

// File: verif/kernel_ctrl_tb.sv
// Kernel control testbench
module kernel_ctrl_tb;

  localparam int PARAM_DEPTH         = 64;
  localparam int KERNEL_RESET_CYCLES = 4;
  localparam int N_UNMAPPED          = 8;
  localparam int N_FETCH             = 12;
  localparam int N_WRITES            = PARAM_DEPTH + N_UNMAPPED + 4;
  localparam int N_READS             = PARAM_DEPTH + N_UNMAPPED + 9;
  localparam int TIMEOUT = 20 * (N_WRITES + N_READS + 2 * N_FETCH) + 2000;
  // Status word bits.
  localparam int ST_START = 1 << kernel_ctrl_pkg::START_BIT;
  localparam int ST_DONE  = 1 << kernel_ctrl_pkg::DONE_BIT;
  localparam int ST_IDLE  = 1 << kernel_ctrl_pkg::IDLE_BIT;
  localparam int ST_IE    = 1 << kernel_ctrl_pkg::IE_BIT;

  logic                         ap_clk;
  logic                         arst_n;
  logic                         reg_req;
  logic                         reg_write;
  kernel_ctrl_pkg::reg_addr_t   reg_addr;
  kernel_ctrl_pkg::reg_data_t   reg_wdata;
  logic                         reg_ack;
  kernel_ctrl_pkg::reg_data_t   reg_rdata;
  logic                         go_valid;
  logic                         go_stop;
  logic                         done_valid;
  logic                         done_stop;
  logic                         interrupt;
  logic                         kernel_reset;
  logic                         param_addr_valid;
  kernel_ctrl_pkg::param_addr_t param_addr;
  logic                         param_addr_stop;
  logic                         param_data_valid;
  kernel_ctrl_pkg::reg_data_t   param_data;
  logic                         param_data_stop;

  kernel_ctrl_pkg::reg_data_t   ref_mem [PARAM_DEPTH];
  kernel_ctrl_pkg::param_addr_t exp_q [$];
  int   errors = 0;
  int   checks = 0;
  int   cycles = 0;
  int   pulse_len = 0;
  int   post_cycles = 0;
  int   pulses_seen = 0;
  logic in_pulse = 1'b0;
  logic kr_prev = 1'b1;
  logic go_taken = 1'b0;
  logic host_ok = 1'b0;
  logic irq_allowed = 1'b0;

  kernel_ctrl_top #(.PARAM_DEPTH(PARAM_DEPTH), .KERNEL_RESET_CYCLES(KERNEL_RESET_CYCLES))
    u_dut (.*);

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // Inputs change one time unit after the rising edge.
  task automatic step();
    @(posedge ap_clk);
    #1;
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED at time %0t: %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Four-phase host access.
  task automatic bus_access(input logic wr, input int addr, input int wdata, output int rdata);
    reg_req   = 1'b1;
    reg_write = wr;
    reg_addr  = kernel_ctrl_pkg::reg_addr_t'(addr);
    reg_wdata = wdata;
    step();
    while (!reg_ack) step();
    rdata   = reg_rdata;
    reg_req = 1'b0;
    step();
    while (reg_ack) step();
  endtask

  task automatic read_check(input int addr, input int exp, input string what);
    int rd;
    bus_access(1'b0, addr, 0, rd);
    check_value(rd, exp, what);
  endtask

  task automatic fetch_addrs();
    int                           sent;
    kernel_ctrl_pkg::param_addr_t a;
    sent = 0;
    a    = kernel_ctrl_pkg::param_addr_t'($urandom_range(0, PARAM_DEPTH - 1));
    while (sent < N_FETCH) begin
      param_addr_valid = ($urandom_range(0, 3) != 0);
      param_addr       = a;
      // Taken on the next edge unless stop is high.
      if (param_addr_valid && !param_addr_stop) begin
        exp_q.push_back(a);
        sent++;
        a = kernel_ctrl_pkg::param_addr_t'($urandom_range(0, PARAM_DEPTH - 1));
      end
      step();
    end
    param_addr_valid = 1'b0;
  endtask

  task automatic fetch_data();
    int                         got;
    logic                       held;
    kernel_ctrl_pkg::reg_data_t held_word;
    got  = 0;
    held = 1'b0;
    while (got < N_FETCH) begin
      param_data_stop = ($urandom_range(0, 2) == 0);
      if (param_data_valid) begin
        if (held) check_value(param_data, held_word, "param_data held under stop");
        if (param_data_stop) begin
          held      = 1'b1;
          held_word = param_data;
        end else begin
          held = 1'b0;
          check_value(exp_q.size() > 0, 1, "data word without an address");
          if (exp_q.size() > 0) check_value(param_data, ref_mem[exp_q.pop_front()], "fetched word");
          got++;
        end
      end else begin
        check_value(held, 0, "param_data_valid dropped under stop");
      end
      step();
    end
    param_data_stop = 1'b0;
  endtask

  // Action model takes go, fetches words and returns done.
  task automatic action_model();
    int delay;
    while (!go_valid) step();
    delay = $urandom_range(0, 5);
    repeat (delay) begin
      step();
      check_value(go_valid, 1, "go_valid dropped before go transfer");
    end
    go_stop = 1'b0;
    step();
    go_stop  = 1'b1;
    go_taken = 1'b1;
    check_value(go_valid, 0, "go_valid after go transfer");
    fork
      fetch_addrs();
      fetch_data();
    join
    check_value(exp_q.size(), 0, "addresses left without data");
    check_value(param_data_valid, 0, "data word beyond the fetched addresses");
    while (!host_ok) step();
    done_valid = 1'b1;
    while (done_stop) step();
    step();
    done_valid = 1'b0;
  endtask

  task automatic kernel_run(input logic ie);
    int ctrl_word;
    int rd;
    ctrl_word = ST_START | (ie ? ST_IE : 0);
    go_taken  = 1'b0;
    host_ok   = 1'b0;
    fork
      action_model();
      begin
        bus_access(1'b1, kernel_ctrl_pkg::CTRL_ADDR, ctrl_word, rd);
        while (!go_taken) step();
        read_check(kernel_ctrl_pkg::CTRL_ADDR, ctrl_word, "status while running");
        // A second start while running is ignored.
        bus_access(1'b1, kernel_ctrl_pkg::CTRL_ADDR, ctrl_word, rd);
        read_check(kernel_ctrl_pkg::CTRL_ADDR, ctrl_word, "status after second start");
        host_ok = 1'b1;
      end
    join
  endtask

  // Kernel reset pulse length and go timing are sampled mid-cycle.
  always @(negedge ap_clk) begin
    if (arst_n) begin
      if (kernel_reset && !kr_prev) begin
        in_pulse    = 1'b1;
        pulse_len   = 0;
        post_cycles = 0;
      end
      if (in_pulse && kernel_reset) begin
        pulse_len++;
        check_value(go_valid, 0, "go_valid inside kernel reset");
      end else if (in_pulse) begin
        post_cycles++;
        check_value(go_valid, post_cycles == 2, "go_valid after kernel reset");
        if (post_cycles == 2) begin
          check_value(pulse_len, KERNEL_RESET_CYCLES, "kernel reset length");
          pulses_seen++;
          in_pulse = 1'b0;
        end
      end
      kr_prev = kernel_reset;
      if (!irq_allowed) check_value(interrupt, 0, "interrupt while not expected");
    end
  end

  always @(posedge ap_clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    int rd;
    int addr;
    int j;
    int tmp;
    int order [PARAM_DEPTH];
    void'($urandom(32'h121c));
    arst_n           = 1'b0;
    reg_req          = 1'b0;
    reg_write        = 1'b0;
    reg_addr         = '0;
    reg_wdata        = '0;
    go_stop          = 1'b1;
    done_valid       = 1'b0;
    param_addr_valid = 1'b0;
    param_addr       = '0;
    param_data_stop  = 1'b0;
    repeat (10) @(posedge ap_clk);
    check_value(kernel_reset, 1, "kernel_reset during reset");
    #1;
    arst_n = 1'b1;
    step();
    check_value({go_valid, interrupt, reg_ack, param_data_valid}, 0, "outputs after reset");
    check_value({done_stop, param_addr_stop}, 2'b10, "stop outputs after reset");
    read_check(kernel_ctrl_pkg::CTRL_ADDR, ST_IDLE, "status after reset");
    // Unmapped addresses below and above the parameter range.
    for (int i = 0; i < N_UNMAPPED; i++) begin
      if (i < N_UNMAPPED / 2) addr = $urandom_range(1, 15);
      else addr = $urandom_range(kernel_ctrl_pkg::PARAM_BASE + PARAM_DEPTH, 4095);
      bus_access(1'b1, addr, $urandom, rd);
      read_check(addr, 0, "unmapped read");
    end
    for (int i = 0; i < PARAM_DEPTH; i++) begin
      ref_mem[i] = $urandom;
      bus_access(1'b1, kernel_ctrl_pkg::PARAM_BASE + i, ref_mem[i], rd);
      order[i] = i;
    end
    for (int i = PARAM_DEPTH - 1; i > 0; i--) begin
      j        = $urandom_range(0, i);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < PARAM_DEPTH; i++) begin
      read_check(kernel_ctrl_pkg::PARAM_BASE + order[i], ref_mem[order[i]], "parameter read");
    end
    kernel_run(1'b1);
    irq_allowed = 1'b1;
    check_value(interrupt, 1, "interrupt after done");
    read_check(kernel_ctrl_pkg::CTRL_ADDR, ST_DONE | ST_IDLE | ST_IE, "status after done");
    check_value(interrupt, 0, "interrupt after status read");
    irq_allowed = 1'b0;
    read_check(kernel_ctrl_pkg::CTRL_ADDR, ST_IDLE | ST_IE, "second status read");
    check_value(pulses_seen, 1, "kernel reset pulses after first run");
    // Second run with the interrupt disabled.
    kernel_run(1'b0);
    step();
    read_check(kernel_ctrl_pkg::CTRL_ADDR, ST_DONE | ST_IDLE, "status after run without IE");
    read_check(kernel_ctrl_pkg::CTRL_ADDR, ST_IDLE, "second status read without IE");
    check_value(pulses_seen, 2, "kernel reset pulses after second run");
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: kernel_ctrl.f
logic/kernel_ctrl_pkg.sv
logic/reg_select.sv
logic/ctrl_regs.sv
logic/param_mem.sv
logic/reset_handler.sv
logic/kernel_ctrl_top.sv
verif/kernel_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the kernel control testbench with Verilator.
set -u
cd "$(dirname "$0")"
log=sim.log

verilator --binary --assert -Wno-fatal --top-module kernel_ctrl_tb \
  -f kernel_ctrl.f -o kernel_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/kernel_ctrl_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$log"; then
  exit 0
fi
exit 1
